// File: src/hazard_pkg.sv
package hazard_pkg;

    // major opcodes the hazard logic cares about
    localparam logic [6:0] OP_LOAD   = 7'h03;
    localparam logic [6:0] OP_JALR   = 7'h67;
    localparam logic [6:0] OP_OP     = 7'h33;   // reg-reg alu
    localparam logic [6:0] OP_OP_IMM = 7'h13;   // reg-imm alu
    localparam logic [6:0] OP_STORE  = 7'h23;
    localparam logic [6:0] OP_BRANCH = 7'h63;

    // writeback source, same coding as the datapath sel_data mux
    localparam logic [1:0] SEL_ALU  = 2'd0;
    localparam logic [1:0] SEL_PC4  = 2'd1;     // link value of jal/jalr
    localparam logic [1:0] SEL_IMM  = 2'd2;     // lui style
    localparam logic [1:0] SEL_LOAD = 2'd3;     // data memory, late result

    // exe operand forward mux selects
    localparam logic [1:0] FWD_NONE = 2'd0;     // register file value
    localparam logic [1:0] FWD_MEM  = 2'd1;     // exe/mem result
    localparam logic [1:0] FWD_WB   = 2'd2;     // mem/wb result

    // one instruction word, two field layouts
    // r_form holds rs2, i_form reuses those bits as immediate
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_form;
        struct packed {
            logic [11:0] imm12;     // upper bits, no rs2 here
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_form;
    } rv_inst_u;

endpackage

// File: src/pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker import hazard_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // id stage, from fetch/decode
    input  logic [31:0] id_inst,
    input  logic        id_wr_en,
    input  logic [1:0]  id_sel_data,

    // stage controls from the stall/flush controller
    input  logic        exe_en,          // 0 holds id/exe
    input  logic        mem_en,          // 0 pushes a bubble into mem
    input  logic        exe_jalr_stall,  // pushes a bubble into exe

    // exe stage record
    output logic [4:0]  exe_rd,
    output logic        exe_wr_en,
    output logic [1:0]  exe_sel_data,
    output logic [4:0]  exe_rs1,
    output logic [4:0]  exe_rs2,

    // mem stage record
    output logic [4:0]  mem_rd,
    output logic        mem_wr_en,
    output logic [1:0]  mem_sel_data,

    // wb stage record
    output logic [4:0]  wb_rd,
    output logic        wb_wr_en
);

    rv_inst_u   id_word;
    logic       has_rs1;
    logic       has_rs2;
    logic [4:0] dec_rs1;
    logic [4:0] dec_rs2;
    logic [4:0] dec_rd;

    assign id_word = id_inst;

    // which source fields are real for this opcode
    always_comb begin
        has_rs1 = 1'b0;
        has_rs2 = 1'b0;
        case (id_word.i_form.opcode)
            OP_OP, OP_STORE, OP_BRANCH: begin
                has_rs1 = 1'b1;
                has_rs2 = 1'b1;     // only these carry rs2
            end
            OP_LOAD, OP_JALR, OP_OP_IMM: begin
                has_rs1 = 1'b1;     // i-form, bits 24:20 are imm
            end
            default: begin
                has_rs1 = 1'b0;     // lui/auipc/jal/system, no sources tracked
                has_rs2 = 1'b0;
            end
        endcase
    end

    // rs1 and rd sit in the same place in both layouts
    assign dec_rs1 = has_rs1 ? id_word.i_form.rs1 : 5'd0;
    assign dec_rs2 = has_rs2 ? id_word.r_form.rs2 : 5'd0;
    assign dec_rd  = id_word.i_form.rd;  // qualified by id_wr_en downstream

    // id/exe record
    // a jalr stall wins over the hold and squashes the slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_rd       <= 5'd0;
            exe_wr_en    <= 1'b0;
            exe_sel_data <= SEL_ALU;
            exe_rs1      <= 5'd0;
            exe_rs2      <= 5'd0;
        end else if (exe_jalr_stall) begin
            exe_rd       <= 5'd0;       // bubble
            exe_wr_en    <= 1'b0;
            exe_sel_data <= SEL_ALU;
            exe_rs1      <= 5'd0;
            exe_rs2      <= 5'd0;
        end else if (exe_en) begin
            exe_rd       <= dec_rd;
            exe_wr_en    <= id_wr_en;
            exe_sel_data <= id_sel_data;
            exe_rs1      <= dec_rs1;
            exe_rs2      <= dec_rs2;
        end
        // else hold, consumer waits for the load
    end

    // exe/mem record
    // a load-use stall leaves the consumer in exe and sends nothing on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd       <= 5'd0;
            mem_wr_en    <= 1'b0;
            mem_sel_data <= SEL_ALU;
        end else if (mem_en) begin
            mem_rd       <= exe_rd;
            mem_wr_en    <= exe_wr_en;
            mem_sel_data <= exe_sel_data;
        end else begin
            mem_rd       <= 5'd0;       // bubble
            mem_wr_en    <= 1'b0;
            mem_sel_data <= SEL_ALU;
        end
    end

    // mem/wb record, never stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rd    <= 5'd0;
            wb_wr_en <= 1'b0;
        end else begin
            wb_rd    <= mem_rd;
            wb_wr_en <= mem_wr_en;
        end
    end

endmodule

// File: src/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import hazard_pkg::*; (
    // exe sources
    input  logic [4:0] exe_rs1,
    input  logic [4:0] exe_rs2,

    // mem producer
    input  logic [4:0] mem_rd,
    input  logic       mem_wr_en,
    input  logic [1:0] mem_sel_data,

    // wb producer
    input  logic [4:0] wb_rd,
    input  logic       wb_wr_en,

    // operand mux selects
    output logic [1:0] fwd_sel_a,
    output logic [1:0] fwd_sel_b,

    // load in mem feeds exe, data not there yet
    output logic       fw_mem_to_exe_a,
    output logic       fw_mem_to_exe_b
);

    logic mem_is_load;

    assign mem_is_load = (mem_sel_data == SEL_LOAD);

    // mem result ready, i.e. anything but a load
    function automatic logic [1:0] fwd_select(
        input logic [4:0] rs,
        input logic [4:0] m_rd,
        input logic       m_wr_en,
        input logic       m_load,
        input logic [4:0] w_rd,
        input logic       w_wr_en
    );
        logic [1:0] sel;
        sel = FWD_NONE;
        if (rs != 5'd0) begin               // x0 is hardwired, never forward
            if (m_wr_en && rs == m_rd) begin
                if (!m_load)
                    sel = FWD_MEM;          // newest value wins
                // load in mem shadows wb, the stall covers it
            end else if (w_wr_en && rs == w_rd) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign fwd_sel_a = fwd_select(exe_rs1, mem_rd, mem_wr_en, mem_is_load, wb_rd, wb_wr_en);
    assign fwd_sel_b = fwd_select(exe_rs2, mem_rd, mem_wr_en, mem_is_load, wb_rd, wb_wr_en);

    // load-use, select stays FWD_NONE, controller stalls one cycle
    assign fw_mem_to_exe_a = (exe_rs1 != 5'd0) && mem_wr_en && mem_is_load
                             && (exe_rs1 == mem_rd);
    assign fw_mem_to_exe_b = (exe_rs2 != 5'd0) && mem_wr_en && mem_is_load
                             && (exe_rs2 == mem_rd);

endmodule

// File: src/sf_controller.sv
`timescale 1ns/1ps

// load-use stalls
//
//   ld    IF ID EXE MEM WB
//   use      IF ID  EXE  -   (held while ld sits in mem, bubble into mem)
//
//   ld    IF ID EXE MEM WB
//   jalr     IF ID  ID  EXE  (held in id, bubble into exe)
module sf_controller import hazard_pkg::*; (
    // id stage
    input  logic [31:0] id_inst,

    // exe record, to spot a load ahead of jalr
    input  logic [1:0]  exe_sel_data,
    input  logic        exe_wr_en,
    input  logic [4:0]  exe_rd,

    // load-use flags from the forwarding unit
    input  logic        fw_mem_to_exe_a,
    input  logic        fw_mem_to_exe_b,

    // stage enables
    output logic        if_en,           // pc and imem
    output logic        id_en,           // if/id register
    output logic        exe_en,          // id/exe register
    output logic        exe_jalr_stall,  // id/exe flush for load then jalr
    output logic        mem_en           // exe/mem register, 0 flushes it
);

    rv_inst_u   id_word;
    logic [6:0] id_opcode;
    logic [4:0] id_rs1;
    logic       exe_load;
    logic       jalr_stall;
    logic       load_stall;

    assign id_word   = id_inst;
    assign id_opcode = id_word.i_form.opcode;
    assign id_rs1    = id_word.i_form.rs1;     // jalr is i-form

    assign exe_load = (exe_sel_data == SEL_LOAD);

    // jalr reads rs1 in id for the target, so a load one ahead is too late
    // no x0 guard here, a load to x0 with jalr x0 costs one spare cycle
    assign jalr_stall = exe_load && exe_wr_en && (id_opcode == OP_JALR)
                        && (id_rs1 == exe_rd);

    // any exe operand waiting on a load in mem
    assign load_stall = fw_mem_to_exe_a || fw_mem_to_exe_b;

    assign if_en          = !(load_stall || jalr_stall);  // both cases hold fetch
    assign id_en          = !(load_stall || jalr_stall);
    assign exe_en         = !load_stall;                  // jalr case lets exe drain
    assign mem_en         = !load_stall;
    assign exe_jalr_stall = jalr_stall;

endmodule

// File: src/hazard_top.sv
`timescale 1ns/1ps

module hazard_top (
    input  logic        clk,
    input  logic        rst_n,

    // id stage from decode
    input  logic [31:0] id_inst,
    input  logic        id_wr_en,
    input  logic [1:0]  id_sel_data,

    // stage enables and flush
    output logic        if_en,
    output logic        id_en,
    output logic        exe_en,
    output logic        mem_en,
    output logic        exe_jalr_stall,

    // exe operand forward selects
    output logic [1:0]  fwd_sel_a,
    output logic [1:0]  fwd_sel_b
);

    // tracker records
    logic [4:0] exe_rd;
    logic       exe_wr_en;
    logic [1:0] exe_sel_data;
    logic [4:0] exe_rs1;
    logic [4:0] exe_rs2;
    logic [4:0] mem_rd;
    logic       mem_wr_en;
    logic [1:0] mem_sel_data;
    logic [4:0] wb_rd;
    logic       wb_wr_en;

    // load-use flags
    logic       fw_mem_to_exe_a;
    logic       fw_mem_to_exe_b;

    pipe_tracker i_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_inst        (id_inst),
        .id_wr_en       (id_wr_en),
        .id_sel_data    (id_sel_data),
        .exe_en         (exe_en),
        .mem_en         (mem_en),
        .exe_jalr_stall (exe_jalr_stall),
        .exe_rd         (exe_rd),
        .exe_wr_en      (exe_wr_en),
        .exe_sel_data   (exe_sel_data),
        .exe_rs1        (exe_rs1),
        .exe_rs2        (exe_rs2),
        .mem_rd         (mem_rd),
        .mem_wr_en      (mem_wr_en),
        .mem_sel_data   (mem_sel_data),
        .wb_rd          (wb_rd),
        .wb_wr_en       (wb_wr_en)
    );

    forwarding_unit i_fwd (
        .exe_rs1         (exe_rs1),
        .exe_rs2         (exe_rs2),
        .mem_rd          (mem_rd),
        .mem_wr_en       (mem_wr_en),
        .mem_sel_data    (mem_sel_data),
        .wb_rd           (wb_rd),
        .wb_wr_en        (wb_wr_en),
        .fwd_sel_a       (fwd_sel_a),
        .fwd_sel_b       (fwd_sel_b),
        .fw_mem_to_exe_a (fw_mem_to_exe_a),
        .fw_mem_to_exe_b (fw_mem_to_exe_b)
    );

    sf_controller i_sf (
        .id_inst         (id_inst),
        .exe_sel_data    (exe_sel_data),
        .exe_wr_en       (exe_wr_en),
        .exe_rd          (exe_rd),
        .fw_mem_to_exe_a (fw_mem_to_exe_a),
        .fw_mem_to_exe_b (fw_mem_to_exe_b),
        .if_en           (if_en),
        .id_en           (id_en),
        .exe_en          (exe_en),
        .exe_jalr_stall  (exe_jalr_stall),
        .mem_en          (mem_en)
    );

endmodule

// File: verification/hazard_checker.sv
`timescale 1ns/1ps

module hazard_checker import hazard_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] id_inst,
    input  logic        id_wr_en,
    input  logic [1:0]  id_sel_data,
    input  logic        if_en,
    input  logic        id_en,
    input  logic        exe_en,
    input  logic        mem_en,
    input  logic        exe_jalr_stall,
    input  logic [1:0]  fwd_sel_a,
    input  logic [1:0]  fwd_sel_b,
    input  logic        done,           // stimulus over, write the report
    output logic        report_ready,
    output int          error_total
);

    // own copy of the stage records
    logic [4:0] s_exe_rd;
    logic       s_exe_wr;
    logic [1:0] s_exe_sel;
    logic [4:0] s_exe_rs1;
    logic [4:0] s_exe_rs2;
    logic [4:0] s_exe_raw_rs2;  // bits 24:20 as fetched, imm for i-form
    logic       s_exe_iform;
    logic [4:0] s_mem_rd;
    logic       s_mem_wr;
    logic [1:0] s_mem_sel;
    logic [4:0] s_wb_rd;
    logic       s_wb_wr;

    logic [8:0] exp_now;
    logic [6:0] id_opc;
    logic       id_known;
    logic       id_two_src;

    int   value_errors = 0;
    int   seq_errors   = 0;
    int   cov_errors   = 0;
    int   cov_fwd_mem  = 0;
    int   cov_fwd_wb   = 0;
    int   cov_ld_stall = 0;
    int   cov_jr_stall = 0;
    int   cov_iform    = 0;
    logic prev_exe_en  = 1'b1;
    logic prev_jalr    = 1'b0;

    initial report_ready = 1'b0;
    initial error_total  = 0;

    // newest producer wins, a load in mem means stall and no forward
    function automatic logic [1:0] pick_source(
        input logic [4:0] src,
        input logic       mem_wr,
        input logic       mem_load,     // mem value arrives too late
        input logic [4:0] m_rd,
        input logic       wb_ok,
        input logic [4:0] w_rd
    );
        if (src == 5'd0)
            return FWD_NONE;
        if (mem_wr && src == m_rd)
            return mem_load ? FWD_NONE : FWD_MEM;
        if (wb_ok && src == w_rd)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    // expected {if_en, id_en, exe_en, mem_en, exe_jalr_stall, fwd_sel_a, fwd_sel_b}
    function automatic logic [8:0] expected_outputs(
        input logic [31:0] inst,
        input logic [4:0]  e_rd,
        input logic        e_wr,
        input logic [1:0]  e_sel,
        input logic [4:0]  e_rs1,
        input logic [4:0]  e_rs2,
        input logic [4:0]  m_rd,
        input logic        m_wr,
        input logic [1:0]  m_sel,
        input logic [4:0]  w_rd,
        input logic        w_wr
    );
        logic       m_load;
        logic       stall_ld;
        logic       stall_jr;
        logic [1:0] sel_a;
        logic [1:0] sel_b;
        m_load   = m_wr && (m_sel == SEL_LOAD);
        stall_ld = (e_rs1 != 5'd0 && m_load && e_rs1 == m_rd)
                   || (e_rs2 != 5'd0 && m_load && e_rs2 == m_rd);
        // jalr target needs rs1 in id, no x0 exception here
        stall_jr = e_wr && (e_sel == SEL_LOAD) && (inst[6:0] == OP_JALR)
                   && (inst[19:15] == e_rd);
        sel_a = pick_source(e_rs1, m_wr, m_load, m_rd, w_wr, w_rd);
        sel_b = pick_source(e_rs2, m_wr, m_load, m_rd, w_wr, w_rd);
        return {!(stall_ld || stall_jr), !(stall_ld || stall_jr), !stall_ld, !stall_ld,
                stall_jr, sel_a, sel_b};
    endfunction

    assign exp_now = expected_outputs(id_inst, s_exe_rd, s_exe_wr, s_exe_sel, s_exe_rs1,
                                      s_exe_rs2, s_mem_rd, s_mem_wr, s_mem_sel,
                                      s_wb_rd, s_wb_wr);

    assign id_opc     = id_inst[6:0];
    assign id_known   = id_opc inside {OP_LOAD, OP_JALR, OP_OP, OP_OP_IMM, OP_STORE, OP_BRANCH};
    assign id_two_src = id_opc inside {OP_OP, OP_STORE, OP_BRANCH};   // r-form readers

    // advance the shadow with the expected enables, not the dut's
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_exe_rd      <= 5'd0;
            s_exe_wr      <= 1'b0;
            s_exe_sel     <= SEL_ALU;
            s_exe_rs1     <= 5'd0;
            s_exe_rs2     <= 5'd0;
            s_exe_raw_rs2 <= 5'd0;
            s_exe_iform   <= 1'b0;
            s_mem_rd      <= 5'd0;
            s_mem_wr      <= 1'b0;
            s_mem_sel     <= SEL_ALU;
            s_wb_rd       <= 5'd0;
            s_wb_wr       <= 1'b0;
        end else begin
            if (exp_now[4]) begin
                s_exe_rd      <= 5'd0;      // squashed slot behind the load
                s_exe_wr      <= 1'b0;
                s_exe_sel     <= SEL_ALU;
                s_exe_rs1     <= 5'd0;
                s_exe_rs2     <= 5'd0;
                s_exe_raw_rs2 <= 5'd0;
                s_exe_iform   <= 1'b0;
            end else if (exp_now[6]) begin
                s_exe_rd      <= id_inst[11:7];
                s_exe_wr      <= id_wr_en;
                s_exe_sel     <= id_sel_data;
                s_exe_rs1     <= id_known ? id_inst[19:15] : 5'd0;
                s_exe_rs2     <= id_two_src ? id_inst[24:20] : 5'd0;
                s_exe_raw_rs2 <= id_inst[24:20];
                s_exe_iform   <= (id_opc == OP_OP_IMM) || (id_opc == OP_LOAD);
            end
            if (exp_now[5]) begin
                s_mem_rd  <= s_exe_rd;
                s_mem_wr  <= s_exe_wr;
                s_mem_sel <= s_exe_sel;
            end else begin
                s_mem_rd  <= 5'd0;          // bubble into mem
                s_mem_wr  <= 1'b0;
                s_mem_sel <= SEL_ALU;
            end
            s_wb_rd <= s_mem_rd;
            s_wb_wr <= s_mem_wr;
        end
    end

    task automatic compare_value(input string name, input logic [1:0] expected,
                                 input logic [1:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAIL %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    // outputs settled half a cycle after the edge
    always @(negedge clk) begin
        compare_value("if_en", {1'b0, exp_now[8]}, {1'b0, if_en});
        compare_value("id_en", {1'b0, exp_now[7]}, {1'b0, id_en});
        compare_value("exe_en", {1'b0, exp_now[6]}, {1'b0, exe_en});
        compare_value("mem_en", {1'b0, exp_now[5]}, {1'b0, mem_en});
        compare_value("exe_jalr_stall", {1'b0, exp_now[4]}, {1'b0, exe_jalr_stall});
        compare_value("fwd_sel_a", exp_now[3:2], fwd_sel_a);
        compare_value("fwd_sel_b", exp_now[1:0], fwd_sel_b);
        if (rst_n) begin
            // the inserted bubble clears either hazard by the next cycle
            if (!exe_en && !prev_exe_en) begin
                seq_errors++;
                $display("ERROR: load-use stall held exe for two cycles in a row at %0t", $time);
            end
            if (exe_jalr_stall && prev_jalr) begin
                seq_errors++;
                $display("ERROR: jalr stall lasted two cycles in a row at %0t", $time);
            end
            if (fwd_sel_a == FWD_MEM || fwd_sel_b == FWD_MEM) cov_fwd_mem++;
            if (fwd_sel_a == FWD_WB || fwd_sel_b == FWD_WB) cov_fwd_wb++;
            if (!exe_en) cov_ld_stall++;
            if (exe_jalr_stall) cov_jr_stall++;
            // imm bits that look like a live rs2 must be ignored
            if (s_exe_iform && s_exe_raw_rs2 != 5'd0
                && ((s_mem_wr && s_exe_raw_rs2 == s_mem_rd)
                    || (s_wb_wr && s_exe_raw_rs2 == s_wb_rd)))
                cov_iform++;
            prev_exe_en <= exe_en;
            prev_jalr   <= exe_jalr_stall;
        end
    end

    always @(posedge clk) begin
        if (done && !report_ready) begin
            if (cov_fwd_mem == 0) cov_errors++;
            if (cov_fwd_wb == 0) cov_errors++;
            if (cov_ld_stall == 0) cov_errors++;
            if (cov_jr_stall == 0) cov_errors++;
            if (cov_iform == 0) cov_errors++;
            if (cov_errors != 0)
                $display("ERROR: random run missed one or more hazard cases");
            $display("errors: value %0d, sequence %0d, coverage %0d",
                     value_errors, seq_errors, cov_errors);
            error_total  <= value_errors + seq_errors + cov_errors;
            report_ready <= 1'b1;
        end
    end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top import hazard_pkg::*; ();

    localparam int NUM_INSTS    = 3000;
    localparam int CYCLE_LIMIT  = 2 * NUM_INSTS + 100;  // each stall costs one cycle
    localparam int DRAIN_CYCLES = 4;                    // empty exe, mem and wb

    logic        clk;
    logic        rst_n        = 1'b0;
    logic [31:0] id_inst      = 32'd0;
    logic        id_wr_en     = 1'b0;
    logic [1:0]  id_sel_data  = SEL_ALU;
    logic        if_en;
    logic        id_en;
    logic        exe_en;
    logic        mem_en;
    logic        exe_jalr_stall;
    logic [1:0]  fwd_sel_a;
    logic [1:0]  fwd_sel_b;
    logic        done         = 1'b0;
    logic        report_ready;
    int          error_total;

    int          sent_count   = 0;
    int          cycle_count  = 0;
    logic [15:0] lfsr_state   = 16'd5;
    logic [7:0]  op_pick;
    logic [7:0]  rd_pick;
    logic [7:0]  rs1_pick;
    logic [7:0]  rs2_pick;
    logic [7:0]  f3_pick;
    logic [6:0]  opc;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = 8'd0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
        end
    endtask

    // load and jalr get two codes each, more load hazards
    function automatic logic [6:0] opcode_for(input logic [2:0] code);
        case (code)
            3'd0, 3'd6: return OP_LOAD;
            3'd1, 3'd7: return OP_JALR;
            3'd2:       return OP_OP;
            3'd3:       return OP_OP_IMM;
            3'd4:       return OP_STORE;
            default:    return OP_BRANCH;
        endcase
    endfunction

    hazard_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_inst        (id_inst),
        .id_wr_en       (id_wr_en),
        .id_sel_data    (id_sel_data),
        .if_en          (if_en),
        .id_en          (id_en),
        .exe_en         (exe_en),
        .mem_en         (mem_en),
        .exe_jalr_stall (exe_jalr_stall),
        .fwd_sel_a      (fwd_sel_a),
        .fwd_sel_b      (fwd_sel_b)
    );

    hazard_checker i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_inst        (id_inst),
        .id_wr_en       (id_wr_en),
        .id_sel_data    (id_sel_data),
        .if_en          (if_en),
        .id_en          (id_en),
        .exe_en         (exe_en),
        .mem_en         (mem_en),
        .exe_jalr_stall (exe_jalr_stall),
        .fwd_sel_a      (fwd_sel_a),
        .fwd_sel_b      (fwd_sel_b),
        .done           (done),
        .report_ready   (report_ready),
        .error_total    (error_total)
    );

    // fetch/decode stand-in, registers x0..x3 only so hazards are common
    always @(posedge clk) begin
        if (rst_n && id_en) begin       // id_en low means hold the word
            if (sent_count < NUM_INSTS) begin
                take_bits(3, op_pick);
                take_bits(2, rd_pick);
                take_bits(2, rs1_pick);
                take_bits(2, rs2_pick);   // imm bits on i-form
                take_bits(3, f3_pick);
                opc = opcode_for(op_pick[2:0]);
                id_inst     <= {7'd0, 3'd0, rs2_pick[1:0], 3'd0, rs1_pick[1:0],
                                f3_pick[2:0], 3'd0, rd_pick[1:0], opc};
                id_wr_en    <= !(opc == OP_STORE || opc == OP_BRANCH);
                id_sel_data <= (opc == OP_LOAD) ? SEL_LOAD :
                               (opc == OP_JALR) ? SEL_PC4 : SEL_ALU;
                sent_count  <= sent_count + 1;
            end else begin
                id_inst     <= 32'd0;     // idle word, no sources, no write
                id_wr_en    <= 1'b0;
                id_sel_data <= SEL_ALU;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= CYCLE_LIMIT) begin
                $display("timeout: only %0d instructions sent in %0d cycles",
                         sent_count, cycle_count);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    initial begin
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait (sent_count == NUM_INSTS);
        repeat (DRAIN_CYCLES) @(posedge clk);
        done <= 1'b1;
        wait (report_ready);
        if (error_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
src/hazard_pkg.sv
src/pipe_tracker.sv
src/forwarding_unit.sv
src/sf_controller.sv
src/hazard_top.sv
verification/hazard_checker.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the hazard unit testbench with verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
